//--- hdl/dec_pkg.sv
/*
   Shared widths, opcodes and the instruction word type for the decode stage.
   Only RV32 base encodings are covered and compressed forms are not decoded.
   All three union views overlay the same 32 bits, so field positions are fixed.
*/
package dec_pkg;

   localparam int xlen       = 32;                    // data word width
   localparam int reg_addr_w = 5;                     // register index width

   // ****************************************
   // major opcodes the decoder recognizes
   // ****************************************
   localparam logic [6:0] opc_op     = 7'b0110011;    // register-register alu
   localparam logic [6:0] opc_op_imm = 7'b0010011;    // register-immediate alu
   localparam logic [6:0] opc_lui    = 7'b0110111;    // load upper immediate
   localparam logic [6:0] opc_auipc  = 7'b0010111;    // add upper immediate to pc
   localparam logic [6:0] opc_jal    = 7'b1101111;    // jump and link

   // ****************************************
   // instruction word, R/I/U views
   // ****************************************
   typedef union packed {
      struct packed {
         logic [6:0]            funct7;               // bit 5 is the alternate op
         logic [reg_addr_w-1:0] rs2;
         logic [reg_addr_w-1:0] rs1;
         logic [2:0]            funct3;
         logic [reg_addr_w-1:0] rd;
         logic [6:0]            opcode;
      } r;
      struct packed {
         logic [11:0]           imm12;                // sign bit at the top
         logic [reg_addr_w-1:0] rs1;
         logic [2:0]            funct3;
         logic [reg_addr_w-1:0] rd;
         logic [6:0]            opcode;
      } i;
      struct packed {
         logic [19:0]           imm20;                // also holds the scrambled j offset
         logic [reg_addr_w-1:0] rd;
         logic [6:0]            opcode;
      } u;
   } dec_instr_u;

endpackage

//--- hdl/dec_decode_if.sv
/*
   Decoded control packet from the decoder to the operand stage.
   Purely combinational bundle with no clock, valid is carried separately.
*/
`timescale 1ns/1ps

interface dec_decode_if import dec_pkg::*; ();

   logic                  rs1_en;                     // rs1 register data used
   logic                  rs2_en;                     // rs2 register data used
   logic                  use_imm;                    // immediate onto operand 2
   logic                  select_pc;                  // pc onto operand 1
   logic                  rd_wen;                     // writes a destination
   logic [reg_addr_w-1:0] rd;                         // destination index
   logic [xlen-1:0]       imm;                        // expanded immediate
   logic [3:0]            alu_op;                     // {alt, funct3}
   logic                  illegal;                    // unknown op or bad index

   modport decoder (
      output rs1_en, rs2_en, use_imm, select_pc, rd_wen,
      output rd, imm, alu_op, illegal
   );

   modport operand (
      input rs1_en, rs2_en, use_imm, select_pc, rd_wen,
      input rd, imm, alu_op, illegal
   );

endinterface

//--- hdl/dec_ib.sv
/*
   One-entry instruction buffer between fetch and decode.
   Fetch inputs are dropped while ex_stall is high, so fetch must hold them.
   Flush wins over stall and also kills an instruction arriving that cycle.
*/
`timescale 1ns/1ps

module dec_ib import dec_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            ex_stall,
   input  logic            flush,
   input  logic            ifu_valid,
   input  logic [xlen-1:0] ifu_instr,
   input  logic [31:1]     ifu_pc,
   output logic            d_valid,
   output dec_instr_u      d_instr,
   output logic [31:1]     d_pc
);

   // ****************************************
   // valid flop
   // ****************************************
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         d_valid <= 1'b0;                             // kill decode slot
      end else if (!ex_stall) begin
         d_valid <= ifu_valid;                        // advance
      end
   end

   // payload only loads on a live fetch
   always_ff @(posedge clk) begin
      if (!ex_stall && ifu_valid) begin
         d_instr <= ifu_instr;                        // raw word into union
         d_pc    <= ifu_pc;
      end
   end

   // ****************************************
   // checks
   // ****************************************
   // a flushed slot never reaches decode, even if a stall is pending
   a_flush_kills_d: assert property (@(posedge clk) flush |=> !d_valid)
      else $error("dec_ib: d_valid high after flush");

endmodule

//--- hdl/dec_decode_ctl.sv
/*
   Instruction decoder for OP, OP-IMM, LUI, AUIPC and JAL.
   Every other opcode is flagged illegal and loses all register enables.
   Register indices at or above num_gpr are illegal as well.
*/
`timescale 1ns/1ps

module dec_decode_ctl import dec_pkg::*; #(
   parameter int num_gpr = 32                         // 32 or 16 registers
) (
   input dec_instr_u           d_instr,
   dec_decode_if.decoder       pkt
);

   localparam logic [reg_addr_w:0] gpr_lim = (reg_addr_w + 1)'(num_gpr);

   logic            is_op;
   logic            is_op_imm;
   logic            is_lui;
   logic            is_auipc;
   logic            is_jal;
   logic            known;
   logic            rs1_used;
   logic            rs2_used;
   logic            bad_idx;
   logic            illegal;
   logic            alt;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_u;
   logic [xlen-1:0] imm_j;

   // ****************************************
   // opcode classes
   // ****************************************
   assign is_op     = d_instr.r.opcode == opc_op;
   assign is_op_imm = d_instr.r.opcode == opc_op_imm;
   assign is_lui    = d_instr.r.opcode == opc_lui;
   assign is_auipc  = d_instr.r.opcode == opc_auipc;
   assign is_jal    = d_instr.r.opcode == opc_jal;
   assign known     = is_op | is_op_imm | is_lui | is_auipc | is_jal;

   assign rs1_used = is_op | is_op_imm;
   assign rs2_used = is_op;

   // every legal class writes rd, so rd is always range checked
   assign bad_idx = ({1'b0, d_instr.r.rd} >= gpr_lim)
                  | (rs1_used & ({1'b0, d_instr.r.rs1} >= gpr_lim))
                  | (rs2_used & ({1'b0, d_instr.r.rs2} >= gpr_lim));
   assign illegal = ~known | bad_idx;

   // ****************************************
   // immediates
   // ****************************************
   assign imm_i = {{20{d_instr.i.imm12[11]}}, d_instr.i.imm12};   // sign-extended
   assign imm_u = {d_instr.u.imm20, 12'b0};                       // low 12 zero
   assign imm_j = {{12{d_instr.u.imm20[19]}},                     // imm[31:20] sign
                   d_instr.u.imm20[7:0],                          // imm[19:12]
                   d_instr.u.imm20[8],                            // imm[11]
                   d_instr.u.imm20[18:9],                         // imm[10:1]
                   1'b0};

   always_comb begin
      pkt.imm = '0;                                   // OP and unknown
      if (is_op_imm) begin
         pkt.imm = imm_i;
      end else if (is_lui || is_auipc) begin
         pkt.imm = imm_u;
      end else if (is_jal) begin
         pkt.imm = imm_j;
      end
   end

   // ****************************************
   // operand controls
   // ****************************************
   // bit 30 only means sub/sra for OP and for the OP-IMM right shifts
   assign alt = d_instr.r.funct7[5] & (is_op | (is_op_imm & (d_instr.r.funct3 == 3'b101)));

   assign pkt.alu_op    = rs1_used ? {alt, d_instr.r.funct3} : 4'b0000;   // add otherwise
   assign pkt.rs1_en    = rs1_used & ~illegal;
   assign pkt.rs2_en    = rs2_used & ~illegal;
   assign pkt.use_imm   = ~is_op;
   assign pkt.select_pc = is_auipc | is_jal;
   assign pkt.rd        = d_instr.r.rd;
   assign pkt.rd_wen    = ~illegal & (d_instr.r.rd != '0);                // x0 never written
   assign pkt.illegal   = illegal;

endmodule

//--- hdl/dec_gpr_ctl.sv
/*
   Architectural register file, two read ports and two write ports.
   No write bypass, a same-cycle read returns the old value.
   Divide writeback wins a same-index collision, x0 and out-of-range writes drop.
*/
`timescale 1ns/1ps

module dec_gpr_ctl import dec_pkg::*; #(
   parameter int num_gpr = 32                         // 32 or 16 registers
) (
   input  logic                  clk,
   input  logic                  reset,
   input  dec_instr_u            d_instr,
   input  logic                  wb_wen,
   input  logic [reg_addr_w-1:0] wb_waddr,
   input  logic [xlen-1:0]       wb_wdata,
   input  logic                  div_wen,
   input  logic [reg_addr_w-1:0] div_waddr,
   input  logic [xlen-1:0]       div_wdata,
   output logic [xlen-1:0]       rs1_data,
   output logic [xlen-1:0]       rs2_data
);

   localparam int aw = $clog2(num_gpr);              // array index width
   localparam logic [reg_addr_w:0] gpr_lim = (reg_addr_w + 1)'(num_gpr);

   logic [xlen-1:0] gpr [num_gpr];                    // entry 0 stays zero

   // ****************************************
   // write ports
   // ****************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_gpr; i++) begin
            gpr[i] <= '0;
         end
      end else begin
         for (int i = 1; i < num_gpr; i++) begin     // skip x0
            if (div_wen && (div_waddr == reg_addr_w'(i))) begin
               gpr[i] <= div_wdata;                   // divide has priority
            end else if (wb_wen && (wb_waddr == reg_addr_w'(i))) begin
               gpr[i] <= wb_wdata;
            end
         end
      end
   end

   // read ports, addresses straight from the buffered word
   function automatic logic [xlen-1:0] rd_port(input logic [reg_addr_w-1:0] idx);
      logic hit;
      hit = ({1'b0, idx} < gpr_lim);                  // x0 comes from the cleared entry 0
      return hit ? gpr[idx[aw-1:0]] : '0;
   endfunction

   assign rs1_data = rd_port(d_instr.r.rs1);
   assign rs2_data = rd_port(d_instr.r.rs2);

   // x0 stays zero across any mix of writebacks, reset included
   a_x0_zero: assert property (@(posedge clk) disable iff (reset)
      (d_instr.r.rs1 == '0) |-> (rs1_data == '0))
      else $error("dec_gpr_ctl: x0 read nonzero");

endmodule

//--- hdl/dec_operand_ctl.sv
/*
   Operand select and the decode-to-execute register.
   Holds everything while ex_stall is high, flush clears ex_valid first.
   Payload outputs are only meaningful while ex_valid is high.
*/
`timescale 1ns/1ps

module dec_operand_ctl import dec_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  ex_stall,
   input  logic                  flush,
   input  logic                  d_valid,
   input  logic [31:1]           d_pc,
   dec_decode_if.operand         pkt,
   input  logic [xlen-1:0]       rs1_data,
   input  logic [xlen-1:0]       rs2_data,
   output logic                  ex_valid,
   output logic [xlen-1:0]       ex_rs1_val,
   output logic [xlen-1:0]       ex_rs2_val,
   output logic [reg_addr_w-1:0] ex_rd,
   output logic                  ex_rd_wen,
   output logic [3:0]            ex_alu_op,
   output logic [31:1]           ex_pc,
   output logic                  ex_illegal
);

   logic [xlen-1:0] op1;
   logic [xlen-1:0] op2;

   // ****************************************
   // operand muxes
   // ****************************************
   assign op1 = pkt.select_pc ? {d_pc, 1'b0} :       // auipc, jal
                pkt.rs1_en    ? rs1_data     : '0;    // lui gets zero
   assign op2 = pkt.use_imm   ? pkt.imm      :
                pkt.rs2_en    ? rs2_data     : '0;    // illegal op gets zero

   // control flops
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         ex_valid   <= 1'b0;
         ex_rd_wen  <= 1'b0;
         ex_illegal <= 1'b0;
      end else if (!ex_stall) begin
         ex_valid   <= d_valid;
         ex_rd_wen  <= d_valid & pkt.rd_wen;         // no write from a bubble
         ex_illegal <= d_valid & pkt.illegal;
      end
   end

   // payload flops
   always_ff @(posedge clk) begin
      if (!ex_stall && d_valid) begin
         ex_rs1_val <= op1;
         ex_rs2_val <= op2;
         ex_rd      <= pkt.rd;
         ex_alu_op  <= pkt.alu_op;
         ex_pc      <= d_pc;
      end
   end

   // stall freezes the whole execute packet, buffer included upstream
   a_stall_valid: assert property (@(posedge clk) disable iff (reset)
      (ex_stall && !flush) |=> $stable(ex_valid))
      else $error("dec_operand_ctl: ex_valid moved under stall");

   a_stall_hold: assert property (@(posedge clk) disable iff (reset)
      (ex_stall && !flush && ex_valid) |=> $stable({ex_rs1_val, ex_rs2_val, ex_rd,
                                                  ex_rd_wen, ex_alu_op, ex_pc, ex_illegal}))
      else $error("dec_operand_ctl: ex packet moved under stall");

endmodule

//--- hdl/dec_top.sv
/*
   Reduced decode stage, fetch to execute in two edges without stall.
   Decoder and register file both work off the buffered word in parallel.
   num_gpr must be 32 or 16.
*/
`timescale 1ns/1ps

module dec_top import dec_pkg::*; #(
   parameter int num_gpr = 32                         // architectural registers
) (
   input  logic                  clk,
   input  logic                  reset,

   // fetch
   input  logic                  ifu_valid,
   input  logic [xlen-1:0]       ifu_instr,
   input  logic [31:1]           ifu_pc,

   // pipe control
   input  logic                  ex_stall,            // level, holds both stages
   input  logic                  flush,               // pulse, kills both stages

   // alu writeback
   input  logic                  wb_wen,
   input  logic [reg_addr_w-1:0] wb_waddr,
   input  logic [xlen-1:0]       wb_wdata,

   // divide writeback
   input  logic                  div_wen,
   input  logic [reg_addr_w-1:0] div_waddr,
   input  logic [xlen-1:0]       div_wdata,

   // toward execute
   output logic                  ex_valid,
   output logic [xlen-1:0]       ex_rs1_val,
   output logic [xlen-1:0]       ex_rs2_val,
   output logic [reg_addr_w-1:0] ex_rd,
   output logic                  ex_rd_wen,
   output logic [3:0]            ex_alu_op,
   output logic [31:1]           ex_pc,
   output logic                  ex_illegal
);

   logic            d_valid;
   dec_instr_u      d_instr;
   logic [31:1]     d_pc;
   logic [xlen-1:0] rs1_data;
   logic [xlen-1:0] rs2_data;

   dec_decode_if dec_pkt ();                          // decoder to operand stage

   // ****************************************
   // stage instances
   // ****************************************
   dec_ib instbuff (
      .clk       (clk),
      .reset     (reset),
      .ex_stall  (ex_stall),
      .flush     (flush),
      .ifu_valid (ifu_valid),
      .ifu_instr (ifu_instr),
      .ifu_pc    (ifu_pc),
      .d_valid   (d_valid),
      .d_instr   (d_instr),
      .d_pc      (d_pc)
   );

   dec_decode_ctl #(.num_gpr(num_gpr)) decode (
      .d_instr   (d_instr),
      .pkt       (dec_pkt.decoder)
   );

   dec_gpr_ctl #(.num_gpr(num_gpr)) arf (
      .clk       (clk),
      .reset     (reset),
      .d_instr   (d_instr),
      .wb_wen    (wb_wen),
      .wb_waddr  (wb_waddr),
      .wb_wdata  (wb_wdata),
      .div_wen   (div_wen),
      .div_waddr (div_waddr),
      .div_wdata (div_wdata),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data)
   );

   dec_operand_ctl operand (
      .clk        (clk),
      .reset      (reset),
      .ex_stall   (ex_stall),
      .flush      (flush),
      .d_valid    (d_valid),
      .d_pc       (d_pc),
      .pkt        (dec_pkt.operand),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .ex_valid   (ex_valid),
      .ex_rs1_val (ex_rs1_val),
      .ex_rs2_val (ex_rs2_val),
      .ex_rd      (ex_rd),
      .ex_rd_wen  (ex_rd_wen),
      .ex_alu_op  (ex_alu_op),
      .ex_pc      (ex_pc),
      .ex_illegal (ex_illegal)
   );

endmodule

//--- bench/tb_dec.sv
/*
   Testbench for the reduced decode stage, built with num_gpr at 32.
   A cycle model of both pipe slots and the register file runs beside the DUT.
   Checks are concurrent assertions sampled on the falling clock edge.
   Inputs change on the falling edge only, outputs are stable there.
*/
`timescale 1ns/1ps

module tb_dec;

   localparam int         num_gpr   = 32;
   localparam int         num_tests = 6;
   localparam logic [5:0] gpr_lim   = 6'(num_gpr);
   localparam logic [6:0] op_reg    = 7'b0110011;        // register-register alu
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_auipc  = 7'b0010111;
   localparam logic [6:0] op_jal    = 7'b1101111;

   logic        clk = 1'b0;
   logic        reset;
   logic        ifu_valid;
   logic [31:0] ifu_instr;
   logic [31:1] ifu_pc;
   logic        ex_stall;
   logic        flush;
   logic        wb_wen;
   logic [4:0]  wb_waddr;
   logic [31:0] wb_wdata;
   logic        div_wen;
   logic [4:0]  div_waddr;
   logic [31:0] div_wdata;
   logic        ex_valid;
   logic [31:0] ex_rs1_val;
   logic [31:0] ex_rs2_val;
   logic [4:0]  ex_rd;
   logic        ex_rd_wen;
   logic [3:0]  ex_alu_op;
   logic [31:1] ex_pc;
   logic        ex_illegal;

   // ****************************************
   // reference model state
   // ****************************************
   logic [31:0] regs [32];                                // x0 kept at zero
   logic        d_v;                                      // decode slot
   logic [31:0] d_ins;
   logic [31:1] d_pc;
   logic        m_v;                                      // execute slot
   logic [31:0] m_rs1;
   logic [31:0] m_rs2;
   logic [4:0]  m_rd;
   logic        m_rd_wen;
   logic        m_ill;
   logic [3:0]  m_alu;
   logic [31:1] m_pc;
   logic [31:0] rng_state;
   int          errors    = 0;
   int          checked   = 0;
   int          passed    = 0;
   int          failed    = 0;
   int          err_start = 0;
   int          chk_start = 0;

   dec_top #(.num_gpr(num_gpr)) uut (.*);

   always #5 clk = ~clk;                                  // 10 ns period

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // lcg step
      return rng_state;
   endfunction

   function automatic logic [4:0] rand_reg();
      logic [31:0] r;
      r = next_rand();
      return r[20:16];                                    // upper bits mix better
   endfunction

   function automatic logic [31:1] rand_pc();
      logic [31:0] r;
      r = next_rand();
      return r[31:1];
   endfunction

   function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, op_imm};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] reg_read(input logic [4:0] idx);
      return (idx == '0 || {1'b0, idx} >= gpr_lim) ? '0 : regs[idx];
   endfunction

   // expected execute packet from the ISA field layout
   task automatic load_ex(input logic [31:0] ins, input logic [31:1] pc);
      logic        op, opi, lui, aui, jal, bad;
      logic [31:0] imm;
      op  = ins[6:0] == op_reg;
      opi = ins[6:0] == op_imm;
      lui = ins[6:0] == op_lui;
      aui = ins[6:0] == op_auipc;
      jal = ins[6:0] == op_jal;
      bad = !(op || opi || lui || aui || jal) || ({1'b0, ins[11:7]} >= gpr_lim)
            || ((op || opi) && {1'b0, ins[19:15]} >= gpr_lim)
            || (op && {1'b0, ins[24:20]} >= gpr_lim);
      imm = opi        ? {{20{ins[31]}}, ins[31:20]} :
            (lui || aui) ? {ins[31:12], 12'b0} :
            jal        ? {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0} : '0;
      m_rs1    = (aui || jal) ? {pc, 1'b0} :
                 ((op || opi) && !bad) ? reg_read(ins[19:15]) : '0;
      m_rs2    = !op  ? imm :
                 !bad ? reg_read(ins[24:20]) : '0;
      m_rd     = ins[11:7];
      m_rd_wen = !bad && ins[11:7] != '0;
      m_ill    = bad;
      m_pc     = pc;
      m_alu    = op  ? {ins[30], ins[14:12]} :
                 opi ? {(ins[14:12] == 3'b101) & ins[30], ins[14:12]} : 4'b0;   // sra/srai
   endtask

   // pipe and register model, advanced on the same edge as the DUT
   always @(posedge clk) begin
      if (reset) begin
         d_v = 1'b0;
         m_v = 1'b0;
         for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
         end
      end else begin
         if (flush) begin
            d_v = 1'b0;                                   // flush beats stall
            m_v = 1'b0;
         end else if (!ex_stall) begin
            if (d_v) begin
               load_ex(d_ins, d_pc);                      // reads before this edge's writes
            end
            m_v = d_v;
            d_v = ifu_valid;
            if (ifu_valid) begin
               d_ins = ifu_instr;
               d_pc  = ifu_pc;
            end
         end
         if (wb_wen && wb_waddr != '0 && {1'b0, wb_waddr} < gpr_lim) begin
            regs[wb_waddr] = wb_wdata;
         end
         if (div_wen && div_waddr != '0 && {1'b0, div_waddr} < gpr_lim) begin
            regs[div_waddr] = div_wdata;                  // last, so divide wins
         end
      end
   end

   // ****************************************
   // checks
   // ****************************************
   chk_valid: assert property (@(negedge clk) disable iff (reset) ex_valid == m_v)
      else begin
         errors++;
         $display("Error at %0t: ex_valid is %b, expected %b", $time, ex_valid, m_v);
      end

   chk_operands: assert property (@(negedge clk) disable iff (reset)
      ex_valid |-> (ex_rs1_val == m_rs1 && ex_rs2_val == m_rs2))
      else begin
         errors++;
         $display("Error at %0t: operands %h %h, expected %h %h", $time,
                  ex_rs1_val, ex_rs2_val, m_rs1, m_rs2);
      end

   chk_controls: assert property (@(negedge clk) disable iff (reset)
      ex_valid |-> (ex_rd == m_rd && ex_rd_wen == m_rd_wen && ex_alu_op == m_alu
                    && ex_pc == m_pc && ex_illegal == m_ill))
      else begin
         errors++;
         $display("Error at %0t: ex controls rd %0d wen %b op %h ill %b, expected %0d %b %h %b",
                  $time, ex_rd, ex_rd_wen, ex_alu_op, ex_illegal, m_rd, m_rd_wen, m_alu, m_ill);
      end

   always @(negedge clk) begin
      if (!reset && ex_valid) begin
         checked++;                                       // packets that met the checks
      end
   end

   // ****************************************
   // stimulus tasks
   // ****************************************
   task automatic issue(input logic [31:0] ins, input logic [31:1] pc);
      ifu_valid = 1'b1;
      ifu_instr = ins;
      ifu_pc    = pc;
      @(negedge clk);
      ifu_valid = 1'b0;
   endtask

   task automatic finish_test(input string name);
      int new_err;
      int seen;
      repeat (3) @(negedge clk);                          // two edges of latency plus margin
      @(posedge clk);                                     // counters settle on negedge
      new_err = errors - err_start;
      seen    = checked - chk_start;
      if (new_err == 0 && seen > 0) begin
         passed++;
         $display("test %s: ok, %0d packets checked", name, seen);
      end else if (seen == 0) begin
         failed++;
         $display("test %s: failed, no instruction reached execute", name);
      end else begin
         failed++;
         $display("test %s: failed, %0d errors", name, new_err);
      end
      err_start = errors;
      chk_start = checked;
      @(negedge clk);
   endtask

   task automatic run_reset_read();
      repeat (4) @(negedge clk);                          // idle, ex_valid stays low
      for (int k = 0; k < 3; k++) begin
         issue(enc_r(1'b0, rand_reg(), rand_reg(), 3'b000, rand_reg()), rand_pc());
      end
   endtask

   task automatic run_random_op();
      logic [31:0] r;
      logic [4:0]  prev;
      prev = 5'd1;
      for (int k = 0; k < 12; k++) begin
         r        = next_rand();
         wb_wen   = 1'b1;                                 // a write every cycle
         wb_waddr = r[4:0];
         wb_wdata = next_rand();
         issue(enc_r(r[30], prev, r[9:5], r[14:12], r[19:15]), rand_pc());
         prev = r[4:0];                                   // read back last write
      end
      wb_wen = 1'b0;
   endtask

   task automatic run_immediates();
      logic [31:0] r;
      for (int k = 0; k < 4; k++) begin
         r = next_rand();
         issue(enc_i(r[31:20], rand_reg(), r[14:12], rand_reg()), rand_pc());
         r = next_rand();
         issue(enc_u(r[31:12], rand_reg(), op_lui), rand_pc());
         r = next_rand();
         issue(enc_u(r[31:12], rand_reg(), op_auipc), rand_pc());
         r = next_rand();
         issue(enc_u(r[31:12], rand_reg(), op_jal), rand_pc());
      end
   endtask

   task automatic run_write_ports();
      logic [4:0] a;
      for (int k = 0; k < 4; k++) begin
         a         = rand_reg() | 5'd1;                   // never x0 here
         wb_wen    = 1'b1;
         wb_waddr  = a;
         wb_wdata  = next_rand();
         div_wen   = 1'b1;
         div_waddr = a;
         div_wdata = next_rand();
         @(negedge clk);
         wb_wen  = 1'b0;
         div_wen = 1'b0;
         issue(enc_r(1'b0, a, a, 3'b000, a), rand_pc());
      end
      wb_wen    = 1'b1;                                   // both ports at x0
      wb_waddr  = 5'd0;
      wb_wdata  = next_rand();
      div_wen   = 1'b1;
      div_waddr = 5'd0;
      div_wdata = next_rand();
      @(negedge clk);
      wb_wen  = 1'b0;
      div_wen = 1'b0;
      issue(enc_r(1'b1, 5'd0, 5'd0, 3'b000, 5'd0), rand_pc());
   endtask

   task automatic run_stall_flush();
      logic [31:0] r;
      int          n;
      n = 0;
      while (n < 16) begin
         r         = next_rand();
         ifu_valid = 1'b1;                                // new word each cycle, dropped if stalled
         ifu_instr = enc_r(r[30], r[24:20], r[19:15], r[14:12], r[11:7]);
         ifu_pc    = 31'(32'h200 + n);
         ex_stall  = r[2];
         wb_wen    = r[3];                                // writes land during stalls too
         wb_waddr  = r[28:24];
         wb_wdata  = next_rand();
         @(negedge clk);
         if (!ex_stall) begin
            n++;
         end
      end
      ifu_valid = 1'b0;
      ex_stall  = 1'b0;
      wb_wen    = 1'b0;
      issue(enc_i(12'h7ff, rand_reg(), 3'b000, rand_reg()), rand_pc());
      ifu_valid = 1'b1;                                   // second one lands in decode
      ifu_instr = enc_u(20'hfffff, 5'd3, op_lui);
      @(negedge clk);
      ifu_instr = enc_u(20'h12345, 5'd4, op_auipc);       // killed at the flush edge
      ex_stall  = 1'b1;
      flush     = 1'b1;
      @(negedge clk);
      flush     = 1'b0;
      ex_stall  = 1'b0;
      ifu_valid = 1'b0;
      repeat (2) @(negedge clk);
      issue(enc_u(20'h00abc, 5'd5, op_jal), rand_pc());   // pipe still moves
   endtask

   task automatic run_illegal();
      logic [6:0]  bad_opc [6];
      logic [31:0] ins;
      bad_opc = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1100111, 7'b1110011, 7'b0001111};
      for (int k = 0; k < 6; k++) begin
         ins      = next_rand();
         ins[6:0] = bad_opc[k];                           // load, store, branch, jalr, system, fence
         issue(ins, rand_pc());
      end
   endtask

   // ****************************************
   // main sequence and watchdog
   // ****************************************
   initial begin
      rng_state = 32'h81f3;
      reset     = 1'b1;
      ifu_valid = 1'b0;
      ifu_instr = '0;
      ifu_pc    = '0;
      ex_stall  = 1'b0;
      flush     = 1'b0;
      wb_wen    = 1'b0;
      wb_waddr  = '0;
      wb_wdata  = '0;
      div_wen   = 1'b0;
      div_waddr = '0;
      div_wdata = '0;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      run_reset_read();
      finish_test("reset read");
      run_random_op();
      finish_test("random writeback and op");
      run_immediates();
      finish_test("immediates and pc");
      run_write_ports();
      finish_test("write port priority");
      run_stall_flush();
      finish_test("stall and flush");
      run_illegal();
      finish_test("illegal opcode");
      $display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
      if (failed == 0 && errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #((num_tests * 200 + 16) * 10);
      $display("watchdog expired, the tests did not finish within their cycle budget");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- all.f
hdl/dec_pkg.sv
hdl/dec_decode_if.sv
hdl/dec_ib.sv
hdl/dec_decode_ctl.sv
hdl/dec_gpr_ctl.sv
hdl/dec_operand_ctl.sv
hdl/dec_top.sv
bench/tb_dec.sv

//--- Makefile
# Verilator flow for the decode stage testbench
TOP := tb_dec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
